/* axi_fields_pkg.sv */
`include "axi_rd_consts.svh"

package axi_fields_pkg;

    typedef logic [`AXI_ID_W-1:0]   axi_id_t;
    typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [7:0]             axi_len_t;     // beats minus one.
    typedef logic [1:0]             axi_burst_t;
    typedef logic [1:0]             axi_resp_t;
    typedef logic [`AXI_DATA_W-1:0] axi_data_t;

    typedef logic [$clog2(`MEM_WORDS)-1:0] mem_idx_t;   // word index into the memory.

    localparam axi_burst_t BURST_FIXED = 2'd0;
    localparam axi_burst_t BURST_WRAP  = 2'd2;

    localparam axi_resp_t RESP_OKAY   = 2'd0;
    localparam axi_resp_t RESP_SLVERR = 2'd2;

endpackage

/* axi_rd_4_merger.sv */
`timescale 1ns/10ps
`include "axi_rd_consts.svh"

module axi_rd_4_merger (
    input  logic          clk,
    input  logic          rst_n,
    axi_ar_if.subordinate up_ar [4],
    axi_r_if.subordinate  up_r [4],
    axi_ar_if.manager     dn_ar,
    axi_r_if.manager      dn_r
);
    import axi_fields_pkg::*;
    import merger_pkg::*;

    localparam int NPORT = 4;
    localparam int ID_W  = $bits(axi_id_t);

    ar_entry_t        ar_head [NPORT];
    logic [NPORT-1:0] cand;
    logic [NPORT-1:0] grant;
    logic [NPORT-1:0] r_sel;
    logic [NPORT-1:0] r_take;
    port_idx_t        win;
    port_idx_t        pick;
    port_idx_t        held_port;
    logic             held;
    logic             dn_ar_hs;

    r_entry_t  r_head;
    logic      r_full;
    logic      r_empty;
    logic      head_last;
    axi_resp_t head_resp;
    axi_data_t head_data;
    axi_id_t   head_tag;

    for (genvar i = 0; i < NPORT; i++) begin : g_port
        localparam axi_id_t TAG = axi_id_t'(`TAG_BASE + i);

        out_cnt_t out_cnt;
        axi_id_t  orig_id;
        logic     ar_full;
        logic     ar_empty;
        logic     tag_full;
        logic     tag_empty;
        logic     ar_hs;
        logic     done;

        assign up_ar[i].ready = !ar_full && (out_cnt < out_cnt_t'(`MAX_OUTSTANDING));
        assign ar_hs = up_ar[i].valid && up_ar[i].ready;
        assign done  = r_take[i] && head_last;    // burst handed back in full.

        sync_fifo #(.WIDTH($bits(ar_entry_t)), .DEPTH(`AR_FIFO_DEPTH)) u_ar_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .push  (ar_hs),
            .din   ({up_ar[i].addr, up_ar[i].len, up_ar[i].burst, up_ar[i].id}),
            .pop   (grant[i] && dn_ar_hs),
            .dout  (ar_head[i]),
            .full  (ar_full),
            .empty (ar_empty)
        );

        // original ids wait here in issue order until the last beat goes back.
        sync_fifo #(.WIDTH(ID_W), .DEPTH(`TAG_FIFO_DEPTH)) u_tag_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .push  (grant[i] && dn_ar_hs),
            .din   (ar_head[i][ID_W-1:0]),
            .pop   (done),
            .dout  (orig_id),
            .full  (tag_full),
            .empty (tag_empty)
        );

        assign cand[i]   = !ar_empty && !tag_full;
        assign r_sel[i]  = !r_empty && !tag_empty && (head_tag == TAG);
        assign r_take[i] = r_sel[i] && up_r[i].ready;

        assign up_r[i].valid = r_sel[i];
        assign up_r[i].id    = orig_id;
        assign up_r[i].data  = head_data;
        assign up_r[i].resp  = head_resp;
        assign up_r[i].last  = head_last;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                out_cnt <= '0;
            end else if (ar_hs && !done) begin
                out_cnt <= out_cnt + 1'b1;
            end else if (done && !ar_hs) begin
                out_cnt <= out_cnt - 1'b1;
            end
        end
    end

    // fixed priority with port a highest.
    always_comb begin
        win = '0;
        for (int i = NPORT - 1; i >= 0; i--) begin
            if (cand[i]) begin
                win = port_idx_t'(i);
            end
        end
    end

    assign pick     = held ? held_port : win;    // offer stays put until taken.
    assign grant    = dn_ar.valid ? (NPORT'(1) << pick) : '0;
    assign dn_ar_hs = dn_ar.valid && dn_ar.ready;

    assign dn_ar.valid = |cand;
    assign {dn_ar.addr, dn_ar.len, dn_ar.burst} = ar_head[pick][$bits(ar_entry_t)-1:ID_W];
    assign dn_ar.id    = axi_id_t'(`TAG_BASE) + axi_id_t'(pick);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held      <= 1'b0;
            held_port <= '0;
        end else begin
            held      <= dn_ar.valid && !dn_ar.ready;
            held_port <= pick;
        end
    end

    sync_fifo #(.WIDTH($bits(r_entry_t)), .DEPTH(`R_FIFO_DEPTH)) u_r_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (dn_r.valid && dn_r.ready),
        .din   ({dn_r.last, dn_r.resp, dn_r.data, dn_r.id}),
        .pop   (|r_take),
        .dout  (r_head),
        .full  (r_full),
        .empty (r_empty)
    );

    assign dn_r.ready = !r_full;
    assign {head_last, head_resp, head_data, head_tag} = r_head;

    a_one_r_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !r_empty |-> $onehot(r_sel))
        else $error("merger: beat at the R FIFO head has no single master");

    a_known_tag: assert property (@(posedge clk) disable iff (!rst_n)
        dn_r.valid && dn_r.ready |->
            (dn_r.id >= axi_id_t'(`TAG_BASE)) && (dn_r.id < axi_id_t'(`TAG_BASE + NPORT)))
        else $error("merger: beat returned with unknown tag %0h", dn_r.id);

endmodule

/* axi_rd_consts.svh */
`ifndef AXI_RD_CONSTS_SVH
`define AXI_RD_CONSTS_SVH

`define AXI_ID_W        4       // master id width.
`define AXI_DATA_W      64
`define AXI_ADDR_W      32      // byte address.

`define AR_FIFO_DEPTH   2       // per master.
`define TAG_FIFO_DEPTH  8
`define R_FIFO_DEPTH    2       // shared by all masters.

`define MAX_OUTSTANDING 8       // bursts in flight per master.

// port a carries this tag downstream and b, c, d take the next three values.
`define TAG_BASE        5

`define MEM_WORDS       256     // in 64-bit words.

`endif

/* axi_rd_ifs.sv */
`timescale 1ns/10ps

interface axi_ar_if;
    import axi_fields_pkg::*;

    axi_id_t    id;
    axi_addr_t  addr;
    axi_len_t   len;
    axi_burst_t burst;
    logic       valid;
    logic       ready;

    modport manager (
        output id, addr, len, burst, valid,
        input  ready
    );

    modport subordinate (
        input  id, addr, len, burst, valid,
        output ready
    );
endinterface

interface axi_r_if;
    import axi_fields_pkg::*;

    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
    logic      valid;
    logic      ready;

    modport manager (
        input  id, data, resp, last, valid,
        output ready
    );

    modport subordinate (
        output id, data, resp, last, valid,
        input  ready
    );
endinterface

/* axi_rd_mem.sv */
`timescale 1ns/10ps
`include "axi_rd_consts.svh"

module axi_rd_mem (
    input  logic                      clk,
    input  logic                      rst_n,
    axi_ar_if.subordinate             ar,
    axi_r_if.subordinate              r,
    input  logic                      wr_en,
    input  axi_fields_pkg::mem_idx_t  wr_idx,
    input  axi_fields_pkg::axi_data_t wr_data
);
    import axi_fields_pkg::*;

    localparam int BYTE_SHIFT = $clog2(`AXI_DATA_W / 8);

    axi_data_t mem [`MEM_WORDS];

    logic      busy;
    logic      step;          // clear for FIXED bursts.
    axi_len_t  beats_left;
    axi_addr_t word_idx;      // kept wide so reads past the end are caught.
    axi_id_t   cur_id;
    logic      in_range;
    logic      ar_hs;
    logic      r_hs;

    assign ar.ready = !busy;
    assign ar_hs    = ar.valid && ar.ready;
    assign r_hs     = r.valid && r.ready;
    assign in_range = (word_idx < axi_addr_t'(`MEM_WORDS));

    assign r.valid = busy;
    assign r.id    = cur_id;
    assign r.last  = (beats_left == '0);
    assign r.data  = in_range ? mem[mem_idx_t'(word_idx)] : '0;
    assign r.resp  = in_range ? RESP_OKAY : RESP_SLVERR;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;    // host load port.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (ar_hs) begin
            busy <= 1'b1;
        end else if (r_hs && r.last) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            cur_id     <= ar.id;
            beats_left <= ar.len;
            word_idx   <= ar.addr >> BYTE_SHIFT;
            step       <= (ar.burst != BURST_FIXED);
        end else if (r_hs) begin
            beats_left <= beats_left - 1'b1;
            if (step) begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

    a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        ar_hs |-> ar.burst != BURST_WRAP)
        else $error("mem: WRAP burst accepted");

    // a burst in progress blocks the next AR until its last beat is taken.
    a_accept_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (r.valid && !(r_hs && r.last)) |=> !ar_hs)
        else $error("mem: AR accepted during a burst");

endmodule

/* axi_rd_subsys_top.sv */
`timescale 1ns/10ps

module axi_rd_subsys_top (
    input  logic                       clk,
    input  logic                       rst_n,

    input  axi_fields_pkg::axi_id_t    a_arid, b_arid, c_arid, d_arid,
    input  axi_fields_pkg::axi_addr_t  a_araddr, b_araddr, c_araddr, d_araddr,
    input  axi_fields_pkg::axi_len_t   a_arlen, b_arlen, c_arlen, d_arlen,
    input  axi_fields_pkg::axi_burst_t a_arburst, b_arburst, c_arburst, d_arburst,
    input  logic                       a_arvalid, b_arvalid, c_arvalid, d_arvalid,
    output logic                       a_arready, b_arready, c_arready, d_arready,

    output axi_fields_pkg::axi_id_t    a_rid, b_rid, c_rid, d_rid,
    output axi_fields_pkg::axi_data_t  a_rdata, b_rdata, c_rdata, d_rdata,
    output axi_fields_pkg::axi_resp_t  a_rresp, b_rresp, c_rresp, d_rresp,
    output logic                       a_rlast, b_rlast, c_rlast, d_rlast,
    output logic                       a_rvalid, b_rvalid, c_rvalid, d_rvalid,
    input  logic                       a_rready, b_rready, c_rready, d_rready,

    input  logic                       mem_wr_en,
    input  axi_fields_pkg::mem_idx_t   mem_wr_idx,
    input  axi_fields_pkg::axi_data_t  mem_wr_data
);
    import axi_fields_pkg::*;

    localparam int NPORT = 4;

    axi_id_t    [0:NPORT-1] ar_id;
    axi_addr_t  [0:NPORT-1] ar_addr;
    axi_len_t   [0:NPORT-1] ar_len;
    axi_burst_t [0:NPORT-1] ar_burst;
    logic       [0:NPORT-1] ar_valid;
    logic       [0:NPORT-1] ar_ready;
    axi_id_t    [0:NPORT-1] r_id;
    axi_data_t  [0:NPORT-1] r_data;
    axi_resp_t  [0:NPORT-1] r_resp;
    logic       [0:NPORT-1] r_last;
    logic       [0:NPORT-1] r_valid;
    logic       [0:NPORT-1] r_ready;

    axi_ar_if up_ar [NPORT] ();
    axi_r_if  up_r [NPORT] ();
    axi_ar_if dn_ar ();
    axi_r_if  dn_r ();

    // master a lands on index 0, the highest priority slot.
    assign ar_id    = {a_arid, b_arid, c_arid, d_arid};
    assign ar_addr  = {a_araddr, b_araddr, c_araddr, d_araddr};
    assign ar_len   = {a_arlen, b_arlen, c_arlen, d_arlen};
    assign ar_burst = {a_arburst, b_arburst, c_arburst, d_arburst};
    assign ar_valid = {a_arvalid, b_arvalid, c_arvalid, d_arvalid};
    assign r_ready  = {a_rready, b_rready, c_rready, d_rready};

    assign {a_arready, b_arready, c_arready, d_arready} = ar_ready;
    assign {a_rid, b_rid, c_rid, d_rid}                 = r_id;
    assign {a_rdata, b_rdata, c_rdata, d_rdata}         = r_data;
    assign {a_rresp, b_rresp, c_rresp, d_rresp}         = r_resp;
    assign {a_rlast, b_rlast, c_rlast, d_rlast}         = r_last;
    assign {a_rvalid, b_rvalid, c_rvalid, d_rvalid}     = r_valid;

    for (genvar i = 0; i < NPORT; i++) begin : g_up
        assign up_ar[i].id    = ar_id[i];
        assign up_ar[i].addr  = ar_addr[i];
        assign up_ar[i].len   = ar_len[i];
        assign up_ar[i].burst = ar_burst[i];
        assign up_ar[i].valid = ar_valid[i];
        assign ar_ready[i]    = up_ar[i].ready;

        assign r_id[i]        = up_r[i].id;
        assign r_data[i]      = up_r[i].data;
        assign r_resp[i]      = up_r[i].resp;
        assign r_last[i]      = up_r[i].last;
        assign r_valid[i]     = up_r[i].valid;
        assign up_r[i].ready  = r_ready[i];
    end

    axi_rd_4_merger u_merger (
        .clk   (clk),
        .rst_n (rst_n),
        .up_ar (up_ar),
        .up_r  (up_r),
        .dn_ar (dn_ar),
        .dn_r  (dn_r)
    );

    axi_rd_mem u_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar      (dn_ar),
        .r       (dn_r),
        .wr_en   (mem_wr_en),
        .wr_idx  (mem_wr_idx),
        .wr_data (mem_wr_data)
    );

endmodule

/* merger_pkg.sv */
package merger_pkg;

    typedef logic [1:0] port_idx_t;    // master a to d.
    typedef logic [4:0] out_cnt_t;

    // address, length, burst and original id of one buffered request.
    typedef logic [$bits(axi_fields_pkg::axi_addr_t) + $bits(axi_fields_pkg::axi_len_t)
                   + $bits(axi_fields_pkg::axi_burst_t)
                   + $bits(axi_fields_pkg::axi_id_t) - 1:0] ar_entry_t;

    // last, resp, data and tag of one returning beat.
    typedef logic [1 + $bits(axi_fields_pkg::axi_resp_t) + $bits(axi_fields_pkg::axi_data_t)
                   + $bits(axi_fields_pkg::axi_id_t) - 1:0] r_entry_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, then judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sources.f --top-module tb_axi_rd_subsys -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"
[ -f sim.log ] && cat sim.log
if [ ! -f sim.log ] || grep -q "Checks failed" sim.log || ! grep -q "All checks passed" sim.log; then
    echo "RESULT: FAIL"
    exit 1
fi
echo "RESULT: PASS"
exit 0

/* sources.f */
+incdir+.
axi_fields_pkg.sv
merger_pkg.sv
axi_rd_ifs.sv
sync_fifo.sv
axi_rd_4_merger.sv
axi_rd_mem.sv
axi_rd_subsys_top.sv
tb_clk_gen.sv
tb_axi_rd_subsys.sv

/* sync_fifo.sv */
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];    // show-ahead.

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else $error("sync_fifo: push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) !(pop && empty))
        else $error("sync_fifo: pop while empty");

endmodule

/* tb_axi_rd_subsys.sv */
`timescale 1ns/10ps
`include "axi_rd_consts.svh"

module tb_axi_rd_subsys;
    import axi_fields_pkg::*;

    localparam int         NM   = 4;
    localparam logic [31:0] SEED = 32'hf79c_a60c;
    localparam axi_burst_t INCR = 2'd1;
    localparam axi_burst_t FIXED = 2'd0;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
        logic      last;
        axi_data_t data;
    } beat_t;

    logic       clk;
    logic       rst_n;
    axi_id_t    arid [NM];
    axi_addr_t  araddr [NM];
    axi_len_t   arlen [NM];
    axi_burst_t arburst [NM];
    logic [NM-1:0] arvalid;
    logic [NM-1:0] arready;
    axi_id_t    rid [NM];
    axi_data_t  rdata [NM];
    axi_resp_t  rresp [NM];
    logic [NM-1:0] rlast;
    logic [NM-1:0] rvalid;
    logic [NM-1:0] rready;
    logic       mem_wr_en;
    mem_idx_t   mem_wr_idx;
    axi_data_t  mem_wr_data;

    axi_data_t shadow [`MEM_WORDS];
    beat_t     exp_q [NM][$];           // expected beats per master, in issue order.
    int        outstanding [NM] = '{default: 0};
    longint    issued_beats = 0;
    logic      quiet = 1'b0;            // high until the first request goes out.
    string     port_tag [NM] = '{"a", "b", "c", "d"};

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    axi_rd_subsys_top uut (
        .clk (clk), .rst_n (rst_n),
        .a_arid (arid[0]), .a_araddr (araddr[0]), .a_arlen (arlen[0]), .a_arburst (arburst[0]),
        .a_arvalid (arvalid[0]), .a_arready (arready[0]), .a_rid (rid[0]), .a_rdata (rdata[0]),
        .a_rresp (rresp[0]), .a_rlast (rlast[0]), .a_rvalid (rvalid[0]), .a_rready (rready[0]),
        .b_arid (arid[1]), .b_araddr (araddr[1]), .b_arlen (arlen[1]), .b_arburst (arburst[1]),
        .b_arvalid (arvalid[1]), .b_arready (arready[1]), .b_rid (rid[1]), .b_rdata (rdata[1]),
        .b_rresp (rresp[1]), .b_rlast (rlast[1]), .b_rvalid (rvalid[1]), .b_rready (rready[1]),
        .c_arid (arid[2]), .c_araddr (araddr[2]), .c_arlen (arlen[2]), .c_arburst (arburst[2]),
        .c_arvalid (arvalid[2]), .c_arready (arready[2]), .c_rid (rid[2]), .c_rdata (rdata[2]),
        .c_rresp (rresp[2]), .c_rlast (rlast[2]), .c_rvalid (rvalid[2]), .c_rready (rready[2]),
        .d_arid (arid[3]), .d_araddr (araddr[3]), .d_arlen (arlen[3]), .d_arburst (arburst[3]),
        .d_arvalid (arvalid[3]), .d_arready (arready[3]), .d_rid (rid[3]), .d_rdata (rdata[3]),
        .d_rresp (rresp[3]), .d_rlast (rlast[3]), .d_rvalid (rvalid[3]), .d_rready (rready[3]),
        .mem_wr_en (mem_wr_en), .mem_wr_idx (mem_wr_idx), .mem_wr_data (mem_wr_data)
    );

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] want);
        report_failure($sformatf("Fail %s: got %0h expected %0h", name, got, want));
    endtask

    // beat k of a burst from the shadow copy and the memory's range rule.
    function automatic beat_t expected_beat(axi_id_t id, axi_addr_t addr, axi_len_t len,
                                            axi_burst_t burst, int k);
        longint byte_addr;
        beat_t  b;
        byte_addr = longint'(addr) + longint'((burst == FIXED) ? 0 : 8 * k);
        b.id   = id;
        b.last = (k == int'(len));
        if (byte_addr >= `MEM_WORDS * 8) begin
            b.data = '0;
            b.resp = RESP_SLVERR;
        end else begin
            b.data = shadow[int'(byte_addr / 8)];
            b.resp = RESP_OKAY;
        end
        return b;
    endfunction

    function automatic int pending_beats();
        int n;
        n = 0;
        for (int m = 0; m < NM; m++) begin
            n += exp_q[m].size();
        end
        return n;
    endfunction

    task automatic preload_memory();
        for (int i = 0; i < `MEM_WORDS; i++) begin
            @(posedge clk);
            #1;
            mem_wr_en   = 1'b1;
            mem_wr_idx  = mem_idx_t'(i);
            mem_wr_data = {$urandom, $urandom};
            shadow[i]   = mem_wr_data;
        end
        @(posedge clk);
        #1;
        mem_wr_en = 1'b0;
    endtask

    task automatic issue_burst(int m, axi_id_t id, axi_addr_t addr, axi_len_t len,
                               axi_burst_t burst);
        for (int k = 0; k <= int'(len); k++) begin
            exp_q[m].push_back(expected_beat(id, addr, len, burst, k));
        end
        issued_beats += longint'(len) + 1;
        @(posedge clk);
        #1;
        quiet      = 1'b0;
        arid[m]    = id;
        araddr[m]  = addr;
        arlen[m]   = len;
        arburst[m] = burst;
        arvalid[m] = 1'b1;
        @(posedge clk);
        while (!arready[m]) @(posedge clk);
        #1;
        arvalid[m] = 1'b0;
    endtask

    task automatic random_bursts(int m, int n);
        axi_addr_t addr;
        axi_len_t  len;
        for (int i = 0; i < n; i++) begin
            len  = axi_len_t'($urandom_range(0, 7));
            addr = axi_addr_t'($urandom_range(0, `MEM_WORDS - 8)) << 3;
            issue_burst(m, axi_id_t'($urandom_range(0, 15)), addr, len, INCR);
        end
    endtask

    task automatic wait_drain();
        while (pending_beats() != 0) @(posedge clk);
    endtask

    // scoreboard sampled on the edge where a beat is taken.
    always @(posedge clk) begin
        beat_t want;
        for (int m = 0; m < NM; m++) begin
            if (arvalid[m] && arready[m]) begin
                outstanding[m]++;
            end
            if (rvalid[m] && rready[m]) begin
                if (exp_q[m].size() == 0) begin
                    report_failure($sformatf("master %s got a beat it never asked for",
                                             port_tag[m]));
                end else begin
                    want = exp_q[m].pop_front();
                    assert (rdata[m] === want.data)
                        else report_mismatch({port_tag[m], "_rdata"}, rdata[m], want.data);
                    assert (rid[m] === want.id)
                        else report_mismatch({port_tag[m], "_rid"},
                                             64'(rid[m]), 64'(want.id));
                    assert (rresp[m] === want.resp)
                        else report_mismatch({port_tag[m], "_rresp"},
                                             64'(rresp[m]), 64'(want.resp));
                    assert (rlast[m] === want.last)
                        else report_mismatch({port_tag[m], "_rlast"},
                                             64'(rlast[m]), 64'(want.last));
                    if (rlast[m]) begin
                        outstanding[m]--;
                    end
                end
            end
            assert (outstanding[m] <= `MAX_OUTSTANDING)
                else report_failure($sformatf("master %s has too many bursts in flight",
                                              port_tag[m]));
        end
    end

    a_single_master: assert property (@(posedge clk) $onehot0(rvalid))
        else report_failure("a beat was offered to more than one master");

    a_idle_state: assert property (@(posedge clk) quiet |-> (rvalid == '0 && arready == '1))
        else report_failure("outputs left their idle state before any request");

    initial begin : watchdog
        forever begin
            #100;
            if (longint'($time) > issued_beats * 40 + 2000) begin
                report_failure("watchdog expired before all bursts came back");
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        mem_wr_en   = 1'b0;
        mem_wr_idx  = '0;
        mem_wr_data = '0;
        arvalid     = '0;
        rready      = '1;
        for (int m = 0; m < NM; m++) begin
            arid[m]    = '0;
            araddr[m]  = '0;
            arlen[m]   = '0;
            arburst[m] = INCR;
        end
        @(posedge clk);
        #1;
        quiet = 1'b1;    // covers reset and the idle time after it.
        preload_memory();

        issue_burst(0, 4'h3, 32'h0000_0040, 8'd7, INCR);
        wait_drain();

        for (int i = 0; i < 4; i++) begin
            issue_burst(1, axi_id_t'(i + 1), axi_addr_t'(32'h100 + 32 * i), 8'd2, INCR);
        end
        wait_drain();

        fork
            random_bursts(0, 4);
            random_bursts(1, 4);
            random_bursts(2, 4);
            random_bursts(3, 4);
        join
        wait_drain();

        issue_burst(2, 4'h9, 32'h0000_0200, 8'd5, FIXED);
        issue_burst(3, 4'hc, 32'h0000_07f0, 8'd3, INCR);    // runs off the end.
        issue_burst(3, 4'hd, 32'h1000_0000, 8'd2, INCR);
        wait_drain();

        @(posedge clk);
        #1;
        rready[0] = 1'b0;
        fork
            for (int i = 0; i < 10; i++) begin
                issue_burst(0, axi_id_t'(i), axi_addr_t'(i * 64), 8'd3, INCR);
            end
            begin
                repeat (60) @(posedge clk);
                #1;
                rready[0] = 1'b1;
            end
        join
        wait_drain();

        repeat (10) @(posedge clk);
        if (pending_beats() == 0 && outstanding.sum() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            report_failure("bursts were still outstanding at the end of the run");
        end
    end

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter real PERIOD     = 4.0,
    parameter int  RST_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;    // released just after an edge.
    end
endmodule
